// ==== hw/imager_pkg.sv ====
`default_nettype none

package imager_pkg;

   localparam int PIXEL_WIDTH = 10;
   localparam int WORD_WIDTH = 16;
   localparam int MAX_COLS = 256;
   localparam int COL_WIDTH = 12;
   localparam int COL_ADDR_WIDTH = $clog2(MAX_COLS);
   localparam int FIFO_DEPTH = 64;
   localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

   localparam int REG_ADDR_WIDTH = 4;
   localparam int REG_DATA_WIDTH = 16;

   localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL = 4'h0;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_SIZE = 4'h1;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_ROWS = 4'h2;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_FRAMES = 4'h3;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS = 4'h4;

   typedef enum logic [1:0] {
      DTYPE_FRAME_START = 2'd0,
      DTYPE_PIXEL       = 2'd1,
      DTYPE_LINE_END    = 2'd2,
      DTYPE_FRAME_END   = 2'd3
   } dtype_e;

   typedef struct packed {
      logic [WORD_WIDTH-PIXEL_WIDTH-1:0] pad;
      logic [PIXEL_WIDTH-1:0]            value;
   } pixel_view_t;

   // Count is the frame number in frame headers and the column count in line ends.
   typedef struct packed {
      logic [COL_WIDTH-1:0]            count;
      logic [WORD_WIDTH-COL_WIDTH-1:0] flags;
   } header_view_t;

   typedef union packed {
      pixel_view_t  pix;
      header_view_t hdr;
   } stream_word_u;

endpackage

`default_nettype wire

// ==== hw/imager_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module imager_rx (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             enable,
   input  wire logic                             fv,
   input  wire logic                             lv,
   input  wire logic [imager_pkg::PIXEL_WIDTH-1:0] pixel,
   output logic                                  valid,
   output imager_pkg::dtype_e                    dtype,
   output imager_pkg::stream_word_u              data,
   output logic [imager_pkg::COL_WIDTH-1:0]      num_cols,
   output logic [imager_pkg::COL_WIDTH-1:0]      num_rows,
   output logic [imager_pkg::COL_WIDTH-1:0]      frame_count
);

   import imager_pkg::*;

   logic                 fv_q;
   logic                 lv_q;
   logic                 active;
   logic [COL_WIDTH-1:0] col_cnt;
   logic [COL_WIDTH-1:0] row_cnt;
   logic [COL_WIDTH-1:0] last_cols;
   logic                 fv_rise;
   logic                 fv_fall;
   logic                 lv_fall;
   logic                 pix_ok;

   assign fv_rise = fv && !fv_q;
   assign fv_fall = !fv && fv_q;
   assign lv_fall = !lv && lv_q;
   assign pix_ok  = fv && lv;

   // The enable is only looked at on the rising edge of fv, so a frame is
   // either captured whole or dropped whole.
   always_ff @(posedge clk) begin
      if (rst) begin
         fv_q        <= 1'b0;
         lv_q        <= 1'b0;
         active      <= 1'b0;
         valid       <= 1'b0;
         col_cnt     <= '0;
         row_cnt     <= '0;
         last_cols   <= '0;
         num_cols    <= '0;
         num_rows    <= '0;
         frame_count <= '0;
      end else begin
         fv_q  <= fv;
         lv_q  <= lv;
         valid <= 1'b0;
         if (fv_rise) begin
            active  <= enable;
            valid   <= enable;
            col_cnt <= '0;
            row_cnt <= '0;
         end else if (active) begin
            if (fv_fall) begin
               active      <= 1'b0;
               valid       <= 1'b1;
               num_cols    <= last_cols;
               num_rows    <= row_cnt;
               frame_count <= frame_count + 1'b1;
            end else if (pix_ok) begin
               valid   <= 1'b1;
               col_cnt <= col_cnt + 1'b1;
            end else if (lv_fall) begin
               valid     <= 1'b1;
               last_cols <= col_cnt;
               col_cnt   <= '0;
               row_cnt   <= row_cnt + 1'b1;
            end
         end
      end
   end

   // Word contents follow the same priority as the valid logic above.
   always_ff @(posedge clk) begin
      data <= '0;
      if (fv_rise) begin
         dtype          <= DTYPE_FRAME_START;
         data.hdr.count <= frame_count;
      end else if (fv_fall) begin
         dtype          <= DTYPE_FRAME_END;
         data.hdr.count <= frame_count;
      end else if (pix_ok) begin
         dtype          <= DTYPE_PIXEL;
         data.pix.value <= pixel;
      end else begin
         dtype          <= DTYPE_LINE_END;
         data.hdr.count <= col_cnt;
      end
   end

endmodule

`default_nettype wire

// ==== hw/line_mirror.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_mirror (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     mirror,
   input  wire logic                     in_valid,
   input  wire imager_pkg::dtype_e       in_dtype,
   input  wire imager_pkg::stream_word_u in_data,
   output logic                          out_valid,
   output imager_pkg::dtype_e            out_dtype,
   output imager_pkg::stream_word_u      out_data
);

   import imager_pkg::*;

   // Two line buffers back to back, selected by the top address bit.
   stream_word_u buf_mem [2*MAX_COLS];

   logic                      mir_q;
   logic                      mir_now;
   logic                      is_start;
   logic                      is_header;
   logic                      busy;
   logic                      store_pix;
   logic                      start_drain;
   logic                      hold_in;
   logic                      pass_in;
   logic                      wr_sel;
   logic [COL_ADDR_WIDTH-1:0] wr_ptr;
   logic                      rd_sel;
   logic [COL_WIDTH-1:0]      rd_ptr;
   logic                      draining;
   logic                      le_pend;
   logic                      hold_valid;
   dtype_e                    hold_dtype;
   stream_word_u              hold_word;
   stream_word_u              le_word;
   stream_word_u              pass_word;

   assign is_start    = in_valid && (in_dtype == DTYPE_FRAME_START);
   assign mir_now     = is_start ? mirror : mir_q;
   assign is_header   = (in_dtype == DTYPE_FRAME_START) || (in_dtype == DTYPE_FRAME_END);
   assign busy        = draining || le_pend || hold_valid;
   assign store_pix   = in_valid && mir_now && (in_dtype == DTYPE_PIXEL);
   assign start_drain = in_valid && mir_now && (in_dtype == DTYPE_LINE_END);
   assign hold_in     = in_valid && is_header && busy;
   assign pass_in     = in_valid && !busy && (!mir_now || is_header);

   always_comb begin
      pass_word = in_data;
      if (is_header) begin
         pass_word.hdr.flags[0] = mir_now;
      end
   end

   // A frame end can land while the last line is still draining; it waits in
   // the hold slot until the line end marker has gone out.
   always_ff @(posedge clk) begin
      if (rst) begin
         mir_q      <= 1'b0;
         wr_sel     <= 1'b0;
         wr_ptr     <= '0;
         rd_sel     <= 1'b0;
         rd_ptr     <= '0;
         draining   <= 1'b0;
         le_pend    <= 1'b0;
         hold_valid <= 1'b0;
         out_valid  <= 1'b0;
      end else begin
         if (is_start) begin
            mir_q <= mirror;
         end
         if (store_pix) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         out_valid <= busy || pass_in;
         if (draining) begin
            if (rd_ptr == '0) begin
               draining <= 1'b0;
               le_pend  <= 1'b1;
            end else begin
               rd_ptr <= rd_ptr - 1'b1;
            end
         end else if (le_pend) begin
            le_pend <= 1'b0;
         end else if (hold_valid) begin
            hold_valid <= 1'b0;
         end
         if (hold_in) begin
            hold_valid <= 1'b1;
         end
         if (start_drain) begin
            wr_sel   <= !wr_sel;
            wr_ptr   <= '0;
            rd_sel   <= wr_sel;
            rd_ptr   <= in_data.hdr.count - 1'b1;
            draining <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (store_pix) begin
         buf_mem[{wr_sel, wr_ptr}] <= in_data;
      end
      if (start_drain) begin
         le_word <= in_data;
      end
      if (hold_in) begin
         hold_dtype <= in_dtype;
         hold_word  <= pass_word;
      end
      if (draining) begin
         out_dtype <= DTYPE_PIXEL;
         out_data  <= buf_mem[{rd_sel, rd_ptr[COL_ADDR_WIDTH-1:0]}];
      end else if (le_pend) begin
         out_dtype <= DTYPE_LINE_END;
         out_data  <= le_word;
      end else if (hold_valid) begin
         out_dtype <= hold_dtype;
         out_data  <= hold_word;
      end else begin
         out_dtype <= in_dtype;
         out_data  <= pass_word;
      end
   end

endmodule

`default_nettype wire

// ==== hw/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     in_valid,
   input  wire imager_pkg::dtype_e       in_dtype,
   input  wire imager_pkg::stream_word_u in_data,
   input  wire logic                     out_ready,
   output logic                          out_valid,
   output imager_pkg::dtype_e            out_dtype,
   output imager_pkg::stream_word_u      out_data,
   output logic                          overflow
);

   import imager_pkg::*;

   stream_word_u word_mem [FIFO_DEPTH];
   dtype_e       type_mem [FIFO_DEPTH];

   // One extra pointer bit tells full from empty.
   logic [FIFO_ADDR_WIDTH:0] wr_ptr;
   logic [FIFO_ADDR_WIDTH:0] rd_ptr;
   logic                     empty;
   logic                     full;
   logic                     push;
   logic                     pop;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                  (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
   assign push  = in_valid && !full;
   assign pop   = !empty && (!out_valid || out_ready);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         out_valid <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         overflow <= in_valid && full;
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr    <= rd_ptr + 1'b1;
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         word_mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= in_data;
         type_mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= in_dtype;
      end
      if (pop) begin
         out_data  <= word_mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
         out_dtype <= type_mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
      end
   end

endmodule

`default_nettype wire

// ==== hw/host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_regs (
   input  wire logic                                clk,
   input  wire logic                                rst,
   input  wire logic                                reg_valid,
   input  wire logic                                reg_write,
   input  wire logic [imager_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
   input  wire logic [imager_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
   input  wire logic [imager_pkg::COL_WIDTH-1:0]    num_cols,
   input  wire logic [imager_pkg::COL_WIDTH-1:0]    num_rows,
   input  wire logic [imager_pkg::COL_WIDTH-1:0]    frame_count,
   input  wire logic                                overflow,
   output logic                                     reg_ready,
   output logic [imager_pkg::REG_DATA_WIDTH-1:0]    reg_rdata,
   output logic                                     reg_rvalid,
   output logic                                     enable,
   output logic                                     mirror
);

   import imager_pkg::*;

   logic                      accept;
   logic                      wr_acc;
   logic                      rd_acc;
   logic                      ovf_sticky;
   logic [REG_DATA_WIDTH-1:0] rd_mux;

   // Every request is taken in the cycle it is presented.
   assign reg_ready = 1'b1;
   assign accept    = reg_valid && reg_ready;
   assign wr_acc    = accept && reg_write;
   assign rd_acc    = accept && !reg_write;

   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         REG_CTRL: begin
            rd_mux[1:0] = {mirror, enable};
         end
         REG_SIZE: begin
            rd_mux[COL_WIDTH-1:0] = num_cols;
         end
         REG_ROWS: begin
            rd_mux[COL_WIDTH-1:0] = num_rows;
         end
         REG_FRAMES: begin
            rd_mux[COL_WIDTH-1:0] = frame_count;
         end
         REG_STATUS: begin
            rd_mux[0] = ovf_sticky;
         end
         default: begin
            rd_mux = '0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         enable     <= 1'b0;
         mirror     <= 1'b0;
         ovf_sticky <= 1'b0;
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= rd_acc;
         if (wr_acc && (reg_addr == REG_CTRL)) begin
            enable <= reg_wdata[0];
            mirror <= reg_wdata[1];
         end
         // A new overflow wins over a clear in the same cycle.
         if (overflow) begin
            ovf_sticky <= 1'b1;
         end else if (wr_acc && (reg_addr == REG_STATUS) && reg_wdata[0]) begin
            ovf_sticky <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_acc) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// ==== hw/imager_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module imager_top (
   input  wire logic                                clk,
   input  wire logic                                rst,
   input  wire logic                                fv,
   input  wire logic                                lv,
   input  wire logic [imager_pkg::PIXEL_WIDTH-1:0]  pixel,
   input  wire logic                                out_ready,
   input  wire logic                                reg_valid,
   input  wire logic                                reg_write,
   input  wire logic [imager_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
   input  wire logic [imager_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
   output logic                                     out_valid,
   output imager_pkg::dtype_e                       out_dtype,
   output imager_pkg::stream_word_u                 out_data,
   output logic                                     reg_ready,
   output logic [imager_pkg::REG_DATA_WIDTH-1:0]    reg_rdata,
   output logic                                     reg_rvalid
);

   import imager_pkg::*;

   logic                 enable;
   logic                 mirror;
   logic                 overflow;
   logic [COL_WIDTH-1:0] num_cols;
   logic [COL_WIDTH-1:0] num_rows;
   logic [COL_WIDTH-1:0] frame_count;
   logic                 rx_valid;
   dtype_e               rx_dtype;
   stream_word_u         rx_data;
   logic                 mir_valid;
   dtype_e               mir_dtype;
   stream_word_u         mir_data;

   imager_rx rx_i (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .fv          (fv),
      .lv          (lv),
      .pixel       (pixel),
      .valid       (rx_valid),
      .dtype       (rx_dtype),
      .data        (rx_data),
      .num_cols    (num_cols),
      .num_rows    (num_rows),
      .frame_count (frame_count)
   );

   line_mirror mirror_i (
      .clk       (clk),
      .rst       (rst),
      .mirror    (mirror),
      .in_valid  (rx_valid),
      .in_dtype  (rx_dtype),
      .in_data   (rx_data),
      .out_valid (mir_valid),
      .out_dtype (mir_dtype),
      .out_data  (mir_data)
   );

   // Back-pressure from the output port ends here.
   stream_fifo fifo_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (mir_valid),
      .in_dtype  (mir_dtype),
      .in_data   (mir_data),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .out_dtype (out_dtype),
      .out_data  (out_data),
      .overflow  (overflow)
   );

   host_regs regs_i (
      .clk         (clk),
      .rst         (rst),
      .reg_valid   (reg_valid),
      .reg_write   (reg_write),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .num_cols    (num_cols),
      .num_rows    (num_rows),
      .frame_count (frame_count),
      .overflow    (overflow),
      .reg_ready   (reg_ready),
      .reg_rdata   (reg_rdata),
      .reg_rvalid  (reg_rvalid),
      .enable      (enable),
      .mirror      (mirror)
   );

endmodule

`default_nettype wire

// ==== test/tb_sensor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sensor (
   input  wire logic                           clk,
   output logic                                fv,
   output logic                                lv,
   output logic [imager_pkg::PIXEL_WIDTH-1:0]  pixel
);

   import imager_pkg::*;

   logic [31:0] lcg_state = 32'hb6f1;
   logic [17:0] exp_q [$];

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int pending();
      return exp_q.size();
   endfunction

   function automatic logic [17:0] pop_expected();
      return exp_q.pop_front();
   endfunction

   function automatic void clear_expected();
      exp_q.delete();
   endfunction

   function automatic void push_word(input dtype_e t, input logic [15:0] w);
      exp_q.push_back({t, w});
   endfunction

   task automatic go_idle();
      fv    = 1'b0;
      lv    = 1'b0;
      pixel = '0;
   endtask

   // Called just after a falling edge, returns just after one. The expected
   // words are queued in the order the output port must deliver them.
   task automatic send_frame(input int cols, input int rows, input int blank,
                             input logic [11:0] frame_no, input logic mirrored,
                             input logic captured);
      logic [PIXEL_WIDTH-1:0] line [$];
      logic [3:0]             flags;
      int                     idx;
      flags = {3'b000, mirrored};
      fv = 1'b1;
      if (captured) push_word(DTYPE_FRAME_START, {frame_no, flags});
      repeat (4) @(negedge clk);
      for (int r = 0; r < rows; r++) begin
         line.delete();
         for (int c = 0; c < cols; c++) begin
            lcg_state = lcg_step(lcg_state);
            lv        = 1'b1;
            pixel     = lcg_state[25:16];
            line.push_back(lcg_state[25:16]);
            if (captured && !mirrored) push_word(DTYPE_PIXEL, 16'(lcg_state[25:16]));
            @(negedge clk);
         end
         lv    = 1'b0;
         pixel = '0;
         if (captured) begin
            for (int c = 0; c < cols; c++) begin
               idx = cols - 1 - c;
               if (mirrored) push_word(DTYPE_PIXEL, 16'(line[idx]));
            end
            push_word(DTYPE_LINE_END, {12'(cols), 4'b0000});
         end
         repeat (blank) @(negedge clk);
      end
      fv = 1'b0;
      if (captured) push_word(DTYPE_FRAME_END, {frame_no, flags});
      repeat (blank) @(negedge clk);
   endtask

endmodule

`default_nettype wire

// ==== test/tb_imager.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_imager;

   import imager_pkg::*;

   // Line blanking must cover the longest mirrored line.
   localparam int BLANK = 32;

   logic                      clk;
   logic                      rst;
   logic                      fv;
   logic                      lv;
   logic [PIXEL_WIDTH-1:0]    pixel;
   logic                      out_ready = 1'b0;
   logic                      reg_valid;
   logic                      reg_write;
   logic [REG_ADDR_WIDTH-1:0] reg_addr;
   logic [REG_DATA_WIDTH-1:0] reg_wdata;
   logic                      out_valid;
   dtype_e                    out_dtype;
   stream_word_u              out_data;
   logic                      reg_ready;
   logic [REG_DATA_WIDTH-1:0] reg_rdata;
   logic                      reg_rvalid;
   logic                      ready_low = 1'b0;
   logic [31:0]               rdy_state = 32'hb6f1;
   logic [17:0]               exp_word;
   int                        xfer_count = 0;
   int                        base;
   int unsigned               cycle_cnt = 0;
   int unsigned               limit;

   imager_top imager_top_i (
      .clk        (clk),
      .rst        (rst),
      .fv         (fv),
      .lv         (lv),
      .pixel      (pixel),
      .out_ready  (out_ready),
      .reg_valid  (reg_valid),
      .reg_write  (reg_write),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .out_valid  (out_valid),
      .out_dtype  (out_dtype),
      .out_data   (out_data),
      .reg_ready  (reg_ready),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid)
   );

   tb_sensor sensor_i (
      .clk   (clk),
      .fv    (fv),
      .lv    (lv),
      .pixel (pixel)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1);
   endtask

   function automatic int frame_len(input int cols, input int rows);
      return 6 + rows * (cols + BLANK) + BLANK;
   endfunction

   task automatic write_reg(input logic [3:0] addr, input logic [15:0] wdata);
      reg_valid = 1'b1;
      reg_write = 1'b1;
      reg_addr  = addr;
      reg_wdata = wdata;
      @(negedge clk);
      reg_valid = 1'b0;
      reg_write = 1'b0;
   endtask

   // Read data must be there one cycle after the request, and for one cycle only.
   task automatic check_reg(input logic [3:0] addr, input logic [15:0] expv, input string name);
      reg_valid = 1'b1;
      reg_write = 1'b0;
      reg_addr  = addr;
      @(negedge clk);
      reg_valid = 1'b0;
      assert (reg_rvalid) else stop_on_error(
         "Read data did not arrive one cycle after the request.");
      assert (reg_rdata == expv) else stop_on_error(
         $sformatf("FAIL reg_rdata (%s): got %h expected %h", name, reg_rdata, expv));
      @(negedge clk);
      assert (!reg_rvalid) else stop_on_error("Read data stayed valid for more than one cycle.");
   endtask

   task automatic wait_drained();
      while (sensor_i.pending() != 0) @(negedge clk);
   endtask

   // Drive out_ready, then check the word that the coming rising edge takes.
   always @(negedge clk) begin
      if (ready_low) begin
         out_ready = 1'b0;
      end else begin
         rdy_state = sensor_i.lcg_step(rdy_state);
         out_ready = rdy_state[20];
      end
      if (!rst) begin
         assert (reg_ready) else stop_on_error(
            $sformatf("FAIL reg_ready: got %h expected %h", reg_ready, 1'b1));
      end
      if (out_valid && out_ready) begin
         assert (sensor_i.pending() > 0) else stop_on_error(
            "An output word arrived when none was expected.");
         exp_word = sensor_i.pop_expected();
         assert (out_dtype == exp_word[17:16]) else stop_on_error(
            $sformatf("FAIL out_dtype: got %h expected %h", out_dtype, exp_word[17:16]));
         assert (out_data == exp_word[15:0]) else stop_on_error(
            $sformatf("FAIL out_data: got %h expected %h", out_data, exp_word[15:0]));
         xfer_count++;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > limit) stop_on_error("The run did not finish within its cycle limit.");
   end

   initial begin
      rst       = 1'b1;
      reg_valid = 1'b0;
      reg_write = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      sensor_i.go_idle();
      limit = 2 * (frame_len(16, 4) + 2 * frame_len(20, 3) + frame_len(8, 2)
                   + frame_len(16, 6)) + 2000;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      write_reg(REG_CTRL, 16'h0003);
      check_reg(REG_CTRL, 16'h0003, "CTRL");
      write_reg(REG_CTRL, 16'h0002);
      check_reg(REG_CTRL, 16'h0002, "CTRL");

      write_reg(REG_CTRL, 16'h0001);
      sensor_i.send_frame(16, 4, BLANK, 12'd0, 1'b0, 1'b1);
      wait_drained();

      write_reg(REG_CTRL, 16'h0003);
      sensor_i.send_frame(20, 3, BLANK, 12'd1, 1'b1, 1'b1);
      wait_drained();

      check_reg(REG_SIZE, 16'd20, "SIZE");
      check_reg(REG_ROWS, 16'd3, "ROWS");
      check_reg(REG_FRAMES, 16'd2, "FRAMES");

      // A frame seen while disabled must leave no trace.
      write_reg(REG_CTRL, 16'h0000);
      sensor_i.send_frame(8, 2, BLANK, 12'd2, 1'b0, 1'b0);
      repeat (40) @(negedge clk);
      check_reg(REG_FRAMES, 16'd2, "FRAMES");
      check_reg(REG_SIZE, 16'd20, "SIZE");
      check_reg(REG_ROWS, 16'd3, "ROWS");

      write_reg(REG_CTRL, 16'h0001);
      ready_low = 1'b1;
      sensor_i.send_frame(16, 6, BLANK, 12'd2, 1'b0, 1'b1);
      repeat (8) @(negedge clk);
      check_reg(REG_STATUS, 16'h0001, "STATUS");
      base      = xfer_count;
      ready_low = 1'b0;
      @(negedge clk);
      while (out_valid) @(negedge clk);
      assert (xfer_count - base >= FIFO_DEPTH) else stop_on_error(
         $sformatf("FAIL drained words: got %h expected at least %h",
                   xfer_count - base, FIFO_DEPTH));
      // The tail of the frame was dropped at the full FIFO.
      sensor_i.clear_expected();
      write_reg(REG_STATUS, 16'h0001);
      check_reg(REG_STATUS, 16'h0000, "STATUS");

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
hw/imager_pkg.sv
hw/imager_rx.sv
hw/line_mirror.sv
hw/stream_fifo.sv
hw/host_regs.sv
hw/imager_top.sv
test/tb_sensor.sv
test/tb_imager.sv

// ==== Makefile ====
# Verilator build and run for the image sensor receive path.

VERILATOR ?= verilator
TOP       ?= tb_imager
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
